//--- Makefile
VERILATOR ?= verilator
TOP ?= bunch_pattern_generator_tb
FLIST ?= flist.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
PASS_TEXT ?= All checks passed
VFLAGS ?= --timing --assert
BUILD_FLAGS ?= -Wno-fatal

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FLIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) $(BUILD_FLAGS) --top-module $(TOP) \
		-f $(FLIST) -Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- bench/bunch_pattern_generator_asserts.sv
`timescale 1ns/1ps

module bunch_pattern_generator_asserts
	import bcm_link_pkg::*;
(
	input logic clock50,
	input logic reset,
	input wb_request_t wb_request,
	input wb_response_t wb_response,
	input logic init_done,
	input logic frame_marker
);

	// count of failed assertions
	int failures = 0;

	// slave answers a strobe from the previous cycle
	ack_after_strobe: assert property (@(posedge clock50) disable iff (reset)
		wb_response.ack |-> $past(wb_request.cyc && wb_request.stb))
		else begin
			failures++;
			$error("ack without a preceding strobe");
		end

	// single cycle ack
	ack_single_cycle: assert property (@(posedge clock50) disable iff (reset)
		wb_response.ack |=> !wb_response.ack)
		else begin
			failures++;
			$error("ack high for two cycles");
		end

	// image is frozen once written
	no_write_after_init: assert property (@(posedge clock50) disable iff (reset)
		init_done |-> !(wb_request.cyc && wb_request.stb))
		else begin
			failures++;
			$error("bus write after init_done");
		end

	marker_needs_init: assert property (@(posedge clock50) disable iff (reset)
		!init_done |-> !frame_marker)
		else begin
			failures++;
			$error("frame_marker before init_done");
		end

endmodule

bind bunch_pattern_generator bunch_pattern_generator_asserts bus_checks (
	.clock50(clock50),
	.reset(reset),
	.wb_request(wb_request),
	.wb_response(wb_response),
	.init_done(init_done),
	.frame_marker(frame_marker)
);

//--- bench/bunch_pattern_generator_tb.sv
`timescale 1ns/1ps

module bunch_pattern_generator_tb
	import bcm_geometry_pkg::*;
();

	// stop is exclusive and 128 lands on address 0
	typedef struct packed {
		int start;
		int stop;
		int frames;
	} stimulus_row_t;

	localparam int row_count = 4;
	// marks a row whose bounds are drawn at run time
	localparam int random_bound = -1;

	stimulus_row_t table_rows [row_count] = '{
		'{0, 128, 1},
		'{48, 64, 3},
		'{56, 57, 4},
		'{random_bound, random_bound, 2}
	};

	logic clock50;
	logic reset;
	address_t play_start;
	address_t play_end;
	logic bit_out;
	logic frame_marker;
	logic init_done;

	int errors = 0;
	int checks = 0;
	int cycles = 0;
	int cycle_limit = 0;
	integer seed;

	bunch_pattern_generator DUT (
		.clock50(clock50),
		.reset(reset),
		.play_start(play_start),
		.play_end(play_end),
		.bit_out(bit_out),
		.frame_marker(frame_marker),
		.init_done(init_done)
	);

	initial begin
		clock50 = 1'b0;
		forever #50 clock50 = ~clock50;
	end

	// run limit set once the table is complete
	always @(posedge clock50) begin
		cycles = cycles + 1;
		if (cycle_limit > 0 && cycles >= cycle_limit) begin
			$display("timed out waiting for frame_marker after %0d cycles", cycles);
			$display("checks: %0d  errors: %0d", checks, errors + 1);
			$display("Checks failed");
			$finish;
		end
	end

	// image word at one ram address taken from the fill map
	function automatic word_t expected_word(int address);
		return pattern_word(fill_map[address / slot_words], address % slot_words);
	endfunction

	// new bounds go in with reset held for two edges
	task automatic apply_reset(stimulus_row_t row);
		@(posedge clock50);
		#1;
		reset = 1'b1;
		play_start = address_t'(row.start);
		play_end = address_t'(row.stop);
		repeat (2) @(posedge clock50);
		#1;
		reset = 1'b0;
	endtask

	// quiet outputs until the image is written
	task automatic check_initialization();
		@(negedge clock50);
		checks++;
		assert (!init_done && !bit_out && !frame_marker) else begin
			errors++;
			$display("outputs not low after reset");
		end
		while (!init_done) begin
			checks++;
			assert (!bit_out && !frame_marker) else begin
				errors++;
				$display("bit_out or frame_marker active before init_done");
			end
			@(negedge clock50);
		end
	endtask

	task automatic wait_frame_marker();
		while (!frame_marker) begin
			checks++;
			assert (init_done) else begin
				errors++;
				$display("init_done dropped before the first frame");
			end
			@(negedge clock50);
		end
	endtask

	// entered on the first bit of a frame
	task automatic check_frames(int start, int length, int frames);
		int total;
		int position;
		int bit_index;
		word_t assembled;
		word_t expected;
		logic marker_expected;
		total = frames * length * word_bits;
		assembled = '0;
		for (int i = 0; i < total; i++) begin
			if (i > 0)
				@(negedge clock50);
			position = (i / word_bits) % length;
			bit_index = i % word_bits;
			marker_expected = (position == 0) && (bit_index == 0);
			checks++;
			assert (frame_marker == marker_expected) else begin
				errors++;
				$display("mismatch frame_marker at bit %0d: got 0x%h expected 0x%h",
					i, frame_marker, marker_expected);
			end
			checks++;
			assert (init_done) else begin
				errors++;
				$display("mismatch init_done at bit %0d: got 0x%h expected 0x1", i, init_done);
			end
			// msb first
			assembled = {assembled[word_bits-2:0], bit_out};
			if (bit_index == word_bits - 1) begin
				expected = expected_word(start + position);
				checks++;
				assert (assembled == expected) else begin
					errors++;
					$display("mismatch bit_out word at address 0x%h: got 0x%h expected 0x%h",
						start + position, assembled, expected);
				end
			end
		end
		// next pass begins with no gap
		@(negedge clock50);
		checks++;
		assert (frame_marker) else begin
			errors++;
			$display("mismatch frame_marker after last frame: got 0x%h expected 0x1",
				frame_marker);
		end
	endtask

	initial begin
		int length;
		int limit;
		reset = 1'b1;
		play_start = '0;
		play_end = '0;
		seed = 32'h6b1ded12;
		limit = 0;
		// short random windows keep the run brief
		for (int r = 0; r < row_count; r++) begin
			if (table_rows[r].start == random_bound) begin
				table_rows[r].start = {$random(seed)} % 120;
				length = 1 + {$random(seed)} % 8;
				table_rows[r].stop = table_rows[r].start + length;
			end
			length = table_rows[r].stop - table_rows[r].start;
			limit = limit + 300 + table_rows[r].frames * length * word_bits * 2;
		end
		cycle_limit = limit;
		for (int r = 0; r < row_count; r++) begin
			length = table_rows[r].stop - table_rows[r].start;
			apply_reset(table_rows[r]);
			check_initialization();
			wait_frame_marker();
			check_frames(table_rows[r].start, length, table_rows[r].frames);
		end
		errors = errors + DUT.bus_checks.failures;
		$display("checks: %0d  errors: %0d", checks, errors);
		if (errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

//--- flist.f
source/bcm_geometry_pkg.sv
source/bcm_link_pkg.sv
source/fill_map_expander.sv
source/waveform_ram.sv
source/playback_sequencer.sv
source/word_serializer.sv
source/bunch_pattern_generator.sv
bench/bunch_pattern_generator_asserts.sv
bench/bunch_pattern_generator_tb.sv

//--- source/bcm_geometry_pkg.sv
package bcm_geometry_pkg;

	// ram word and serializer width
	localparam int word_bits = 8;
	// words per bucket slot
	localparam int slot_words = 8;
	localparam int slot_count = 16;
	// whole image, one slot after the other
	localparam int ram_words = slot_count * slot_words;
	localparam int address_bits = 7;

	typedef logic [word_bits-1:0] word_t;
	typedef logic [address_bits-1:0] address_t;

	// pattern of one bucket slot
	typedef enum logic [1:0] {
		pattern_empty,
		pattern_pilot,
		pattern_short_train,
		pattern_full_train
	} pattern_kind_t;

	// filled words at the start of a slot
	function automatic int unsigned fill_length(pattern_kind_t kind);
		case (kind)
			pattern_pilot: return 1;
			pattern_short_train: return 4;
			pattern_full_train: return 8;
			default: return 0;
		endcase
	endfunction

	// one entry per slot
	// two trains separated by a pilot, abort gap at the end
	localparam pattern_kind_t fill_map [slot_count] = '{
		pattern_full_train, pattern_full_train, pattern_full_train, pattern_full_train,
		pattern_full_train, pattern_full_train, pattern_short_train, pattern_pilot,
		pattern_full_train, pattern_full_train, pattern_full_train, pattern_full_train,
		pattern_full_train, pattern_full_train, pattern_short_train, pattern_empty
	};

	// word at a position inside a slot of the given kind
	function automatic word_t pattern_word(pattern_kind_t kind, int unsigned position);
		if (position >= fill_length(kind))
			return 8'h00;
		// f0, 0f, then a gap word, repeating
		case (position % 3)
			0: return 8'hf0;
			1: return 8'h0f;
			default: return 8'h00;
		endcase
	endfunction

endpackage

//--- source/bcm_link_pkg.sv
package bcm_link_pkg;

	import bcm_geometry_pkg::*;

	// wishbone classic, master to slave
	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		address_t adr;
		word_t dat;
	} wb_request_t;

	// wishbone classic, slave to master
	// writes only, so no read data
	typedef struct packed {
		logic ack;
	} wb_response_t;

	// one word handed from sequencer to serializer
	typedef struct packed {
		word_t data;
		// first word of a pass through the window
		logic frame_start;
	} playback_word_t;

	// fill map expander fsm
	typedef enum logic [1:0] {
		expand_write,
		expand_wait_ack,
		expand_done
	} expander_state_t;

endpackage

//--- source/bunch_pattern_generator.sv
`timescale 1ns/1ps

module bunch_pattern_generator
	import bcm_geometry_pkg::*;
	import bcm_link_pkg::*;
(
	input logic clock50,
	input logic reset,
	input address_t play_start,
	input address_t play_end,
	output logic bit_out,
	output logic frame_marker,
	output logic init_done
);

	// image write bus
	wb_request_t wb_request;
	wb_response_t wb_response;
	// playback read port
	logic read_enable;
	address_t read_address;
	word_t read_data;
	// words to the serializer
	playback_word_t playback_word;
	logic word_valid;

	// stage one, build the image
	fill_map_expander expander (
		.clock50(clock50),
		.reset(reset),
		.wb_request(wb_request),
		.wb_response(wb_response),
		.init_done(init_done)
	);

	waveform_ram ram (
		.clock50(clock50),
		.reset(reset),
		.wb_request(wb_request),
		.wb_response(wb_response),
		.read_enable(read_enable),
		.read_address(read_address),
		.read_data(read_data)
	);

	// stage two, walk the window
	playback_sequencer sequencer (
		.clock50(clock50),
		.reset(reset),
		.init_done(init_done),
		.play_start(play_start),
		.play_end(play_end),
		.read_enable(read_enable),
		.read_address(read_address),
		.read_data(read_data),
		.playback_word(playback_word),
		.word_valid(word_valid)
	);

	// stage three, one bit per clock
	word_serializer serializer (
		.clock50(clock50),
		.reset(reset),
		.playback_word(playback_word),
		.word_valid(word_valid),
		.bit_out(bit_out),
		.frame_marker(frame_marker)
	);

endmodule

//--- source/fill_map_expander.sv
`timescale 1ns/1ps

module fill_map_expander
	import bcm_geometry_pkg::*;
	import bcm_link_pkg::*;
(
	input logic clock50,
	input logic reset,
	output wb_request_t wb_request,
	input wb_response_t wb_response,
	output logic init_done
);

	expander_state_t state;
	// current slot and word inside it
	logic [$clog2(slot_count)-1:0] slot_index;
	logic [$clog2(slot_words)-1:0] word_index;
	logic [$clog2(slot_count)-1:0] next_slot;
	logic [$clog2(slot_words)-1:0] next_word;
	logic last_word;

	// write request for one word of the image
	function automatic wb_request_t write_request(
		logic [$clog2(slot_count)-1:0] slot,
		logic [$clog2(slot_words)-1:0] word
	);
		wb_request_t request;
		request.cyc = 1'b1;
		request.stb = 1'b1;
		request.we = 1'b1;
		// slot in the upper address bits
		request.adr = {slot, word};
		request.dat = pattern_word(fill_map[slot], word);
		return request;
	endfunction

	// word counter wraps into the next slot
	always_comb begin
		next_word = word_index + 1'b1;
		next_slot = slot_index;
		if (word_index == slot_words - 1)
			next_slot = slot_index + 1'b1;
	end

	assign last_word = (slot_index == slot_count - 1) && (word_index == slot_words - 1);

	always_ff @(posedge clock50) begin
		if (reset) begin
			state <= expand_write;
			slot_index <= '0;
			word_index <= '0;
			wb_request <= '0;
			init_done <= 1'b0;
		end else begin
			case (state)
				expand_write: begin
					// first word, bus idle until now
					wb_request <= write_request(slot_index, word_index);
					state <= expand_wait_ack;
				end
				expand_wait_ack: begin
					// hold the request until the slave acks
					if (wb_response.ack) begin
						if (last_word) begin
							wb_request <= '0;
							init_done <= 1'b1;
							state <= expand_done;
						end else begin
							// back to back, next word right away
							slot_index <= next_slot;
							word_index <= next_word;
							wb_request <= write_request(next_slot, next_word);
						end
					end
				end
				default: begin
					// image complete, stay here until reset
					state <= expand_done;
				end
			endcase
		end
	end

endmodule

//--- source/playback_sequencer.sv
`timescale 1ns/1ps

module playback_sequencer
	import bcm_geometry_pkg::*;
	import bcm_link_pkg::*;
(
	input logic clock50,
	input logic reset,
	input logic init_done,
	input address_t play_start,
	input address_t play_end,
	output logic read_enable,
	output address_t read_address,
	input word_t read_data,
	output playback_word_t playback_word,
	output logic word_valid
);

	logic running;
	// one read every word_bits cycles
	logic [$clog2(word_bits)-1:0] pace;
	address_t address;
	address_t next_address;
	// exclusive end of the window, latched
	address_t window_end;
	// next read is the window start
	logic first_word;
	// frame flag of the read in flight
	logic read_frame;
	logic frame_start;

	// wraps mod ram_words, so end equal to start plays all 128 words
	assign next_address = address + 1'b1;

	always_ff @(posedge clock50) begin
		if (reset) begin
			running <= 1'b0;
			pace <= '0;
			read_enable <= 1'b0;
			read_frame <= 1'b0;
			word_valid <= 1'b0;
			frame_start <= 1'b0;
		end else begin
			read_enable <= 1'b0;
			// ram data and flag arrive together
			word_valid <= read_enable;
			frame_start <= read_frame;
			if (!running) begin
				// wait for the image
				if (init_done)
					running <= 1'b1;
				pace <= '0;
			end else begin
				pace <= pace + 1'b1;
				if (pace == '0) begin
					read_enable <= 1'b1;
					read_frame <= first_word;
				end
			end
		end
	end

	// window bounds and address, no reset needed
	always_ff @(posedge clock50) begin
		if (!running) begin
			address <= play_start;
			window_end <= play_end;
			first_word <= 1'b1;
		end else if (pace == '0) begin
			read_address <= address;
			if (next_address == window_end) begin
				// wrap, resample bounds
				address <= play_start;
				window_end <= play_end;
				first_word <= 1'b1;
			end else begin
				address <= next_address;
				first_word <= 1'b0;
			end
		end
	end

	assign playback_word.data = read_data;
	assign playback_word.frame_start = frame_start;

endmodule

//--- source/waveform_ram.sv
`timescale 1ns/1ps

module waveform_ram
	import bcm_geometry_pkg::*;
	import bcm_link_pkg::*;
(
	input logic clock50,
	input logic reset,
	input wb_request_t wb_request,
	output wb_response_t wb_response,
	input logic read_enable,
	input address_t read_address,
	output word_t read_data
);

	// the waveform image
	word_t memory [ram_words];
	logic write_strobe;

	// new cycle seen by the slave
	// the ack cycle itself is the tail of the previous write
	assign write_strobe = wb_request.cyc && wb_request.stb && !wb_response.ack;

	// single cycle ack, one edge after stb
	always_ff @(posedge clock50) begin
		if (reset)
			wb_response.ack <= 1'b0;
		else
			wb_response.ack <= write_strobe;
	end

	// write lands on the same edge that raises ack
	always_ff @(posedge clock50) begin
		if (write_strobe && wb_request.we)
			memory[wb_request.adr] <= wb_request.dat;
	end

	// registered read port
	// data one cycle after the request
	always_ff @(posedge clock50) begin
		if (read_enable)
			read_data <= memory[read_address];
	end

endmodule

//--- source/word_serializer.sv
`timescale 1ns/1ps

module word_serializer
	import bcm_geometry_pkg::*;
	import bcm_link_pkg::*;
(
	input logic clock50,
	input logic reset,
	input playback_word_t playback_word,
	input logic word_valid,
	output logic bit_out,
	output logic frame_marker
);

	// msb leaves first
	word_t shift_register;
	logic frame_flag;

	always_ff @(posedge clock50) begin
		if (reset) begin
			shift_register <= '0;
			frame_flag <= 1'b0;
		end else if (word_valid) begin
			shift_register <= playback_word.data;
			frame_flag <= playback_word.frame_start;
		end else begin
			// zeros shift in behind the word
			shift_register <= shift_register << 1;
			// marker only on the first bit
			frame_flag <= 1'b0;
		end
	end

	assign bit_out = shift_register[word_bits-1];
	assign frame_marker = frame_flag;

endmodule
